//--- nnPkg.sv
`default_nettype none

package nnPkg;

	localparam int numInputs = 15;
	localparam int numHidden = 6;
	localparam int numClasses = 4;
	localparam int fracBits = 13; // Activations and weights both carry 13 fractional bits.

	typedef logic [15:0] activation;
	typedef logic signed [31:0] weight;

	typedef struct packed {
		logic valid;
		activation [numInputs-1:0] act;
	} inputBeat;

	typedef struct packed {
		logic valid;
		activation [numHidden-1:0] act;
	} hiddenBeat;

	typedef struct packed {
		logic valid;
		activation [numClasses-1:0] act;
	} scoreBeat;

	typedef struct packed {
		logic valid;
		logic [$clog2(numClasses)-1:0] classIndex;
		activation score;
	} classResult;

	// Row n holds the weights of hidden neuron n, column j pairs with input j.
	localparam weight [0:numHidden-1][0:numInputs-1] hiddenWeightsDefault = '{
		'{ 3120, -2210,  1875,  4402,  -990,  2650, -3305,  1210,
		    760, -1544,  2987,   415, -2760,  1902,   640 },
		'{-1780,  3655,  2204,  -615,  1390, -2890,  4120,   905,
		  -1320,  2475,  -340,  3050,  1110, -2045,  2530 },
		'{ 2290,  1460, -3015,  2780,  3345,  -705,  1580, -2460,
		   3890,   560, -1995,  1245,  2870,   730, -1180 },
		'{-2540,   890,  3215,  1650, -2120,  4005,   285,  2310,
		   -875, -1690,  3460, -2280,  1725,  2960,  1035 },
		'{ 1405, -3110,   990, -1465,  2835,  1170,  2555,  -640,
		   2095,  3725,   815, -1905,  -530,  3380,  2215 },
		'{ 2875,  2040, -1250,  3590,   450, -2635, -1815,  3270,
		   1520,  -960,  2145,  2690, -3185,   605,  1840 }
	};

	// Every hidden bias stays below one LSB of the output, so a zero sample leaves the
	// hidden layer at zero.
	localparam weight [0:numHidden-1] hiddenBiasDefault = '{
		-1442,
		3071,
		-2210,
		905,
		-4020,
		1733
	};

	localparam weight [0:numClasses-1][0:numHidden-1] outputWeightsDefault = '{
		'{ 3410, -1275,  2250,  1880, -2045,  2765 },
		'{-1530,  2985,  1745, -2210,  3150,  1395 },
		'{ 2620,  1915, -2875,  3340,  1260, -1685 },
		'{ 1145, -2390,  3025,  2470,  -985,  2815 }
	};

	// Classes 0 and 1 start level, class 2 starts below zero and is clamped by ReLU.
	localparam weight [0:numClasses-1] outputBiasDefault = '{
		40960,
		40960,
		-24576,
		16384
	};

endpackage

`default_nettype wire

//--- neuron.sv
`default_nettype none

module neuron
#(
	parameter int NumIn = nnPkg::numInputs,
	parameter nnPkg::weight [0:NumIn-1] Weights = '0,
	parameter nnPkg::weight Bias = '0
)
(
	input logic clk,
	input logic reset,
	input nnPkg::activation [NumIn-1:0] act,
	output nnPkg::activation out
);

	localparam int SumWidth = $bits(nnPkg::weight);
	localparam int ActWidth = $bits(nnPkg::activation);

	nnPkg::activation [NumIn-1:0] actReg;
	logic [SumWidth-1:0] products [NumIn];
	logic [SumWidth-1:0] macSum;
	logic [SumWidth-1:0] sumReg;

	// Stage one captures the activations.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			actReg <= '0;
		end
		else
		begin
			actReg <= act;
		end
	end

	always_comb
	begin
		for (int i = 0; i < NumIn; i++)
		begin
			products[i] = SumWidth'(actReg[i]) * $unsigned(Weights[i]); // Wraps modulo 2^32.
		end
	end

	always_comb
	begin
		macSum = $unsigned(Bias);
		for (int i = 0; i < NumIn; i++)
		begin
			macSum = macSum + products[i];
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sumReg <= '0;
		end
		else
		begin
			sumReg <= macSum;
		end
	end

	// ReLU on the sign bit, then drop the extra fraction bits of the product.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			out <= '0;
		end
		else if (sumReg[SumWidth-1])
		begin
			out <= '0;
		end
		else
		begin
			out <= sumReg[nnPkg::fracBits +: ActWidth];
		end
	end

endmodule

`default_nettype wire

//--- denseLayer.sv
`default_nettype none

module denseLayer
#(
	parameter type InBeat = nnPkg::inputBeat,
	parameter type OutBeat = nnPkg::hiddenBeat,
	parameter int NumIn = nnPkg::numInputs,
	parameter int NumOut = nnPkg::numHidden,
	parameter nnPkg::weight [0:NumOut-1][0:NumIn-1] Weights = '0,
	parameter nnPkg::weight [0:NumOut-1] Bias = '0
)
(
	input logic clk,
	input logic reset,
	input InBeat in,
	output OutBeat out
);

	localparam int Latency = 3; // Input, sum and output registers of a neuron.

	logic [Latency-1:0] validPipe;
	nnPkg::activation [NumOut-1:0] neuronOut;

	for (genvar n = 0; n < NumOut; n++)
	begin : genNeuron
		neuron
		#(
			.NumIn(NumIn),
			.Weights(Weights[n]),
			.Bias(Bias[n])
		)
		neuronInst
		(
			.clk(clk),
			.reset(reset),
			.act(in.act),
			.out(neuronOut[n])
		);
	end

	// The valid flag walks beside the data so it lines up with the neuron outputs.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validPipe <= '0;
		end
		else
		begin
			validPipe <= {validPipe[Latency-2:0], in.valid};
		end
	end

	assign out.valid = validPipe[Latency-1];
	assign out.act = neuronOut;

endmodule

`default_nettype wire

//--- argMax.sv
`default_nettype none

module argMax
(
	input logic clk,
	input logic reset,
	input nnPkg::scoreBeat scores,
	output nnPkg::classResult result
);

	localparam int IndexWidth = $clog2(nnPkg::numClasses);

	logic [IndexWidth-1:0] bestIndex;
	nnPkg::activation bestScore;

	// A later class must beat the best so far outright, so a tie keeps the lower index.
	always_comb
	begin
		bestIndex = '0;
		bestScore = scores.act[0];
		for (int i = 1; i < nnPkg::numClasses; i++)
		begin
			if (scores.act[i] > bestScore)
			begin
				bestIndex = IndexWidth'(i);
				bestScore = scores.act[i];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			result <= '0;
		end
		else
		begin
			result.valid <= scores.valid;
			result.classIndex <= bestIndex;
			result.score <= bestScore;
		end
	end

endmodule

`default_nettype wire

//--- mlpTop.sv
`default_nettype none

module mlpTop
#(
	parameter nnPkg::weight [0:nnPkg::numHidden-1][0:nnPkg::numInputs-1] HiddenWeights =
		nnPkg::hiddenWeightsDefault,
	parameter nnPkg::weight [0:nnPkg::numHidden-1] HiddenBias =
		nnPkg::hiddenBiasDefault,
	parameter nnPkg::weight [0:nnPkg::numClasses-1][0:nnPkg::numHidden-1] OutputWeights =
		nnPkg::outputWeightsDefault,
	parameter nnPkg::weight [0:nnPkg::numClasses-1] OutputBias =
		nnPkg::outputBiasDefault
)
(
	input logic clk,
	input logic reset,
	input nnPkg::inputBeat sample,
	output nnPkg::scoreBeat scores,
	output nnPkg::classResult result
);

	nnPkg::hiddenBeat hidden;

	denseLayer
	#(
		.InBeat(nnPkg::inputBeat),
		.OutBeat(nnPkg::hiddenBeat),
		.NumIn(nnPkg::numInputs),
		.NumOut(nnPkg::numHidden),
		.Weights(HiddenWeights),
		.Bias(HiddenBias)
	)
	hiddenLayer
	(
		.clk(clk),
		.reset(reset),
		.in(sample),
		.out(hidden)
	);

	// Class scores leave the chip here as well as feeding the selector.
	denseLayer
	#(
		.InBeat(nnPkg::hiddenBeat),
		.OutBeat(nnPkg::scoreBeat),
		.NumIn(nnPkg::numHidden),
		.NumOut(nnPkg::numClasses),
		.Weights(OutputWeights),
		.Bias(OutputBias)
	)
	outputLayer
	(
		.clk(clk),
		.reset(reset),
		.in(hidden),
		.out(scores)
	);

	argMax selector
	(
		.clk(clk),
		.reset(reset),
		.scores(scores),
		.result(result)
	);

endmodule

`default_nettype wire

//--- mlp_assertions.sv
`default_nettype none

module mlpAssertions
(
	input logic clk,
	input logic reset,
	input nnPkg::inputBeat sample,
	input nnPkg::scoreBeat scores,
	input nnPkg::classResult result
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int IndexWidth = $clog2(nnPkg::numClasses);

	logic failed = 1'b0; // Sticky, the testbench watches it.

	function automatic nnPkg::activation reluScale(input logic [31:0] sum);
		if (sum[31])
		begin
			return '0;
		end
		return sum[28:13]; // Drop the 13 extra fraction bits of the product.
	endfunction

	// Reference model of both layers, every sum wraps modulo 2^32.
	function automatic nnPkg::activation [nnPkg::numClasses-1:0] expectScores(
		input nnPkg::activation [nnPkg::numInputs-1:0] x
	);
		nnPkg::activation [nnPkg::numHidden-1:0] h;
		nnPkg::activation [nnPkg::numClasses-1:0] s;
		logic [31:0] acc;
		logic [31:0] w;
		for (int n = 0; n < nnPkg::numHidden; n++)
		begin
			acc = nnPkg::hiddenBiasDefault[n];
			for (int j = 0; j < nnPkg::numInputs; j++)
			begin
				w = nnPkg::hiddenWeightsDefault[n][j];
				acc = acc + {16'h0000, x[j]} * w;
			end
			h[n] = reluScale(acc);
		end
		for (int c = 0; c < nnPkg::numClasses; c++)
		begin
			acc = nnPkg::outputBiasDefault[c];
			for (int n = 0; n < nnPkg::numHidden; n++)
			begin
				w = nnPkg::outputWeightsDefault[c][n];
				acc = acc + {16'h0000, h[n]} * w;
			end
			s[c] = reluScale(acc);
		end
		return s;
	endfunction

	function automatic logic [IndexWidth-1:0] expectWinner(
		input nnPkg::activation [nnPkg::numInputs-1:0] x
	);
		nnPkg::activation [nnPkg::numClasses-1:0] s;
		logic [IndexWidth-1:0] best;
		s = expectScores(x);
		best = '0;
		for (int i = 1; i < nnPkg::numClasses; i++)
		begin
			if (s[i] > s[best])
			begin
				best = IndexWidth'(i); // Only a strictly higher score moves the winner.
			end
		end
		return best;
	endfunction

	function automatic nnPkg::activation expectWinnerScore(
		input nnPkg::activation [nnPkg::numInputs-1:0] x
	);
		nnPkg::activation [nnPkg::numClasses-1:0] s;
		s = expectScores(x);
		return s[expectWinner(x)];
	endfunction

	resetClears: assert property (@(posedge clk)
		reset |=> (!scores.valid && scores.act == '0 && result == '0))
		else
		begin
			failed = 1'b1;
			$error("FAIL at %0t: outputs not cleared during or just after reset", $time);
		end

	validDelay: assert property (@(posedge clk) disable iff (reset)
		(scores.valid == $past(sample.valid, 6)) && (result.valid == $past(sample.valid, 7)))
		else
		begin
			failed = 1'b1;
			$error("FAIL at %0t: valid does not follow the sample by 6 and 7 cycles", $time);
		end

	scoresMatch: assert property (@(posedge clk) disable iff (reset)
		scores.valid |-> (scores.act == expectScores($past(sample.act, 6))))
		else
		begin
			failed = 1'b1;
			$error("FAIL at %0t: class scores %h differ from the model", $time, scores.act);
		end

	resultMatch: assert property (@(posedge clk) disable iff (reset)
		result.valid |-> (result.classIndex == expectWinner($past(sample.act, 7))
			&& result.score == expectWinnerScore($past(sample.act, 7))))
		else
		begin
			failed = 1'b1;
			$error("FAIL at %0t: class %0d score %0d differ from the model", $time,
				result.classIndex, result.score);
		end

	// Class 2 has a negative bias, so an empty sample must clamp it.
	zeroClamp: assert property (@(posedge clk) disable iff (reset)
		(scores.valid && $past(sample.act, 6) == '0) |-> (scores.act[2] == '0))
		else
		begin
			failed = 1'b1;
			$error("FAIL at %0t: zero sample left class 2 above zero", $time);
		end

	zeroTie: assert property (@(posedge clk) disable iff (reset)
		(result.valid && $past(sample.act, 7) == '0) |-> (result.classIndex == '0))
		else
		begin
			failed = 1'b1;
			$error("FAIL at %0t: tie on a zero sample did not pick class 0", $time);
		end

endmodule

bind mlpTop mlpAssertions checks
(
	.clk(clk),
	.reset(reset),
	.sample(sample),
	.scores(scores),
	.result(result)
);

`default_nettype wire

//--- tbMlp.sv
`default_nettype none

module tbMlp;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int resetCycles = 8;
	localparam int stimCycles = 200;
	localparam int drainCycles = 20;
	localparam int cycleLimit = resetCycles + stimCycles + drainCycles;
	localparam int randomSamples = 100;
	localparam int burstSamples = 50;

	logic clk = 1'b0;
	logic reset;
	nnPkg::inputBeat sample;
	nnPkg::scoreBeat scores;
	nnPkg::classResult result;

	integer seed = 32'h12c7;
	int cycleCount = 0;
	int stimCount = 0;
	logic stimulusDone = 1'b0;

	mlpTop DUT
	(
		.clk(clk),
		.reset(reset),
		.sample(sample),
		.scores(scores),
		.result(result)
	);

	always #50 clk = ~clk; // 100 ns period.

	// Twelve-bit activations keep most sums clear of the 32-bit wrap.
	task automatic drawActs(output nnPkg::activation [nnPkg::numInputs-1:0] acts);
		for (int j = 0; j < nnPkg::numInputs; j++)
		begin
			acts[j] = 16'($random(seed)) & 16'h0fff;
		end
	endtask

	task automatic applySample(
		input logic valid,
		input nnPkg::activation [nnPkg::numInputs-1:0] acts
	);
		@(negedge clk);
		sample.valid = valid;
		sample.act = acts;
		stimCount++;
	endtask

	initial
	begin
		nnPkg::activation [nnPkg::numInputs-1:0] acts;
		reset = 1'b1;
		sample = '0;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		for (int i = 0; i < randomSamples; i++)
		begin
			drawActs(acts);
			applySample(1'b1, acts);
			if (i % 10 == 9)
			begin
				drawActs(acts);
				applySample(1'b0, acts); // A gap in valid must reach the result as a gap.
			end
		end

		// Empty sample, then noise without valid, then the empty sample again.
		applySample(1'b1, '0);
		drawActs(acts);
		applySample(1'b0, acts);
		applySample(1'b1, '0);

		for (int i = 0; i < burstSamples; i++)
		begin
			drawActs(acts);
			applySample(1'b1, acts);
		end

		while (stimCount < stimCycles)
		begin
			drawActs(acts);
			applySample((stimCount % 3) == 0, acts);
		end
		stimulusDone = 1'b1;

		@(negedge clk);
		sample = '0;
		repeat (drainCycles) @(posedge clk);

		if (DUT.checks.failed)
		begin
			$display("TESTS FAILED");
			$fatal(1, "an assertion on the DUT outputs failed");
		end
		else
		begin
			$display("TESTS PASSED");
			$finish;
		end
	end

	initial
	begin
		wait (DUT.checks.failed === 1'b1);
		$display("TESTS FAILED");
		$fatal(1, "an assertion on the DUT outputs failed, stopping at the first error");
	end

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit && !stimulusDone)
		begin
			$display("TESTS FAILED");
			$fatal(1, "timeout after %0d cycles with stimulus still running", cycleCount);
		end
	end

endmodule

`default_nettype wire

//--- sources.f
nnPkg.sv
neuron.sv
denseLayer.sv
argMax.sv
mlpTop.sv
mlp_assertions.sv
tbMlp.sv

//--- Makefile
# Verilator build and run of the MLP testbench.

VERILATOR ?= verilator
TOP ?= tbMlp
FILELIST ?= sources.f
OBJDIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --assert -j 0
RUNFLAGS ?= +verilator+error+limit+100
FAILTEXT ?= TESTS FAILED

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINARY := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BINARY)
	./$(BINARY) $(RUNFLAGS) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAILTEXT)" $(LOG); then \
		echo "Simulation failed, see $(LOG)."; exit 1; \
	fi; \
	if [ $$status -ne 0 ]; then \
		echo "Simulator exited with status $$status."; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
